// File: design/l2_params.svh
// ##########################################################
// L2 cache geometry
// way count, set count and field widths of the tag pipeline
// ##########################################################

`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

`define L2_NUM_WAYS 4
`define L2_SET_INDEX_WIDTH 6
`define L2_NUM_SETS (1 << `L2_SET_INDEX_WIDTH)
`define L2_ADDR_WIDTH 26 // line address, no byte offset
`define L2_TAG_WIDTH (`L2_ADDR_WIDTH - `L2_SET_INDEX_WIDTH)
`define L2_LINE_WIDTH 512
`define L2_MASK_WIDTH 64

`endif

// File: design/l2_req_pkg.sv
// ##########################################################
// L2 request types
// fields of a core or restarted request entering the pipe
// ##########################################################

`default_nettype none

`include "l2_params.svh"

package l2_req_pkg;

	typedef logic [1:0] l2_unit_t;
	typedef logic [1:0] l2_strand_t;
	typedef logic [2:0] l2_op_t; // passed along untouched
	typedef logic [$clog2(`L2_NUM_WAYS)-1:0] l2_way_t;
	typedef logic [`L2_ADDR_WIDTH-1:0] l2_addr_t;
	typedef logic [`L2_LINE_WIDTH-1:0] l2_line_t;
	typedef logic [`L2_MASK_WIDTH-1:0] l2_mask_t;

	// one request as it travels down the stages
	typedef struct packed {
		l2_unit_t unit;
		l2_strand_t strand;
		l2_op_t op;
		l2_addr_t address;
		l2_line_t data;
		l2_mask_t mask;
	} l2_req_t;

endpackage

`default_nettype wire

// File: design/l2_tag_pkg.sv
// ##########################################################
// L2 tag lookup types
// tag and set fields, lookup result and pipeline response
// ##########################################################

`default_nettype none

`include "l2_params.svh"

package l2_tag_pkg;

	import l2_req_pkg::*;

	typedef logic [`L2_TAG_WIDTH-1:0] l2_tag_t;
	typedef logic [`L2_SET_INDEX_WIDTH-1:0] l2_set_t;

	// all ways of one set
	typedef struct packed {
		l2_tag_t [`L2_NUM_WAYS-1:0] tags;
		logic [`L2_NUM_WAYS-1:0] valid;
	} l2_lookup_t;

	typedef struct packed {
		l2_req_t req;
		logic has_sm_data;
		logic hit;
		l2_way_t way; // hit, fill or victim way
		l2_line_t fill_line;
	} l2_resp_t;

	function automatic l2_set_t addr_set(input l2_addr_t addr);
		return addr[`L2_SET_INDEX_WIDTH-1:0];
	endfunction

	function automatic l2_tag_t addr_tag(input l2_addr_t addr);
		return addr[`L2_ADDR_WIDTH-1:`L2_SET_INDEX_WIDTH];
	endfunction

endpackage

`default_nettype wire

// File: design/l2_arb.sv
// ##########################################################
// L2 arbiter stage
// picks a fill restart over a core request and registers it
// ##########################################################

`default_nettype none
`timescale 1ns/1ps

module l2_arb
(
	input wire clk,
	input wire rst,
	input wire stall_pipeline,
	input wire core_valid,
	input wire l2_req_pkg::l2_req_t core_req,
	output logic core_accept,
	input wire sm_valid,
	input wire l2_req_pkg::l2_addr_t sm_addr,
	input wire l2_req_pkg::l2_way_t sm_fill_way,
	input wire l2_req_pkg::l2_line_t sm_data,
	input wire init_busy,
	output logic arb_valid,
	output l2_req_pkg::l2_req_t arb_req,
	output logic arb_has_sm_data,
	output l2_req_pkg::l2_way_t arb_sm_fill_way,
	output l2_req_pkg::l2_line_t arb_sm_data
);

	import l2_req_pkg::*;

	l2_req_t sm_req;
	logic take_core;

	// restart only knows its line address
	assign sm_req = '{unit: '0, strand: '0, op: '0, address: sm_addr, data: '0, mask: '0};

	assign take_core = core_valid && !sm_valid && !init_busy;
	assign core_accept = take_core && !stall_pipeline;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			arb_valid <= 1'b0;
			arb_has_sm_data <= 1'b0;
		end
		else if (!stall_pipeline)
		begin
			arb_valid <= sm_valid || take_core;
			arb_has_sm_data <= sm_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			arb_req <= sm_valid ? sm_req : core_req; // restart wins
			arb_sm_fill_way <= sm_fill_way;
			arb_sm_data <= sm_data;
		end
	end

endmodule

`default_nettype wire

// File: design/l2_cache_tag.sv
// ##########################################################
// L2 tag stage
// per-way tag and valid memories, fill write, set lookup
// and the clearing sweep that runs after reset
// ##########################################################

`default_nettype none
`timescale 1ns/1ps

`include "l2_params.svh"

module l2_cache_tag
(
	input wire clk,
	input wire rst,
	input wire stall_pipeline,
	input wire arb_valid,
	input wire l2_req_pkg::l2_req_t arb_req,
	input wire arb_has_sm_data,
	input wire l2_req_pkg::l2_way_t arb_sm_fill_way,
	input wire l2_req_pkg::l2_line_t arb_sm_data,
	input wire l2_req_pkg::l2_way_t lru_way,
	output l2_tag_pkg::l2_set_t lru_set,
	output logic init_busy,
	output logic tag_valid,
	output l2_req_pkg::l2_req_t tag_req,
	output logic tag_has_sm_data,
	output l2_req_pkg::l2_way_t tag_sm_fill_way,
	output l2_req_pkg::l2_line_t tag_sm_data,
	output l2_tag_pkg::l2_lookup_t tag_lookup,
	output l2_req_pkg::l2_way_t tag_lru_way
);

	import l2_tag_pkg::*;

	l2_tag_t tag_mem [`L2_NUM_WAYS][`L2_NUM_SETS];
	logic valid_mem [`L2_NUM_WAYS][`L2_NUM_SETS];
	l2_set_t init_set; // sweep pointer
	l2_set_t req_set;
	l2_tag_t req_tag;
	logic fill_write;

	assign req_set = addr_set(arb_req.address);
	assign req_tag = addr_tag(arb_req.address);
	assign lru_set = req_set;
	assign fill_write = arb_valid && arb_has_sm_data && !stall_pipeline;

	// one set per cycle until the last one is cleared
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			init_busy <= 1'b1;
			init_set <= '0;
		end
		else if (init_busy)
		begin
			init_set <= init_set + 1'b1;
			if (&init_set)
				init_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (init_busy)
		begin
			for (int w = 0; w < `L2_NUM_WAYS; w++)
			begin
				tag_mem[w][init_set] <= '0;
				valid_mem[w][init_set] <= 1'b0;
			end
		end
		else if (fill_write)
		begin
			// restarted line becomes resident in the fill way
			tag_mem[arb_sm_fill_way][req_set] <= req_tag;
			valid_mem[arb_sm_fill_way][req_set] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tag_valid <= 1'b0;
			tag_has_sm_data <= 1'b0;
		end
		else if (!stall_pipeline)
		begin
			tag_valid <= arb_valid;
			tag_has_sm_data <= arb_has_sm_data;
		end
	end

	// lookup sees the memories as they were before this edge
	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			tag_req <= arb_req;
			tag_sm_fill_way <= arb_sm_fill_way;
			tag_sm_data <= arb_sm_data;
			tag_lru_way <= lru_way;
			for (int w = 0; w < `L2_NUM_WAYS; w++)
			begin
				tag_lookup.tags[w] <= tag_mem[w][req_set];
				tag_lookup.valid[w] <= valid_mem[w][req_set];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/l2_cache_lru.sv
// ##########################################################
// L2 pseudo-LRU
// three tree bits per set, read toward the oldest way
// ##########################################################

`default_nettype none
`timescale 1ns/1ps

`include "l2_params.svh"

module l2_cache_lru
(
	input wire clk,
	input wire rst,
	input wire l2_tag_pkg::l2_set_t set_index,
	output l2_req_pkg::l2_way_t lru_way,
	input wire update,
	input wire l2_tag_pkg::l2_set_t update_set,
	input wire l2_req_pkg::l2_way_t mru_way
);

	// bit0 selects the pair, bit1 ways 0/1, bit2 ways 2/3
	logic [2:0] lru_bits [`L2_NUM_SETS];
	logic [2:0] cur_bits;

	assign cur_bits = lru_bits[set_index];
	assign lru_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int s = 0; s < `L2_NUM_SETS; s++)
				lru_bits[s] <= '0;
		end
		else if (update)
		begin
			// point the path away from the way just used
			lru_bits[update_set][0] <= ~mru_way[1];
			if (mru_way[1])
				lru_bits[update_set][2] <= ~mru_way[0];
			else
				lru_bits[update_set][1] <= ~mru_way[0];
		end
	end

endmodule

`default_nettype wire

// File: design/l2_tag_check.sv
// ##########################################################
// L2 tag check stage
// hit detection, victim choice, LRU update and response
// ##########################################################

`default_nettype none
`timescale 1ns/1ps

`include "l2_params.svh"

module l2_tag_check
(
	input wire clk,
	input wire rst,
	input wire stall_pipeline,
	input wire tag_valid,
	input wire l2_req_pkg::l2_req_t tag_req,
	input wire tag_has_sm_data,
	input wire l2_req_pkg::l2_way_t tag_sm_fill_way,
	input wire l2_req_pkg::l2_line_t tag_sm_data,
	input wire l2_tag_pkg::l2_lookup_t tag_lookup,
	input wire l2_req_pkg::l2_way_t tag_lru_way,
	output logic lru_update,
	output l2_tag_pkg::l2_set_t lru_set,
	output l2_req_pkg::l2_way_t lru_mru_way,
	output logic resp_valid,
	output l2_tag_pkg::l2_resp_t resp
);

	import l2_req_pkg::*;
	import l2_tag_pkg::*;

	l2_tag_t req_tag;
	logic [`L2_NUM_WAYS-1:0] hit_vec;
	logic cache_hit;
	logic has_free;
	l2_way_t hit_way;
	l2_way_t free_way;
	l2_way_t pick_way;

	assign req_tag = addr_tag(tag_req.address);

	always_comb
	begin
		hit_way = '0;
		free_way = '0;
		for (int w = `L2_NUM_WAYS - 1; w >= 0; w--)
		begin
			hit_vec[w] = tag_lookup.valid[w] && (tag_lookup.tags[w] == req_tag);
			if (hit_vec[w])
				hit_way = l2_way_t'(w);
			if (!tag_lookup.valid[w])
				free_way = l2_way_t'(w); // lowest invalid wins
		end
	end

	assign cache_hit = |hit_vec;
	assign has_free = !(&tag_lookup.valid);
	assign pick_way = tag_has_sm_data ? tag_sm_fill_way :
		cache_hit ? hit_way :
		has_free ? free_way : tag_lru_way;

	assign lru_update = tag_valid && !stall_pipeline;
	assign lru_set = addr_set(tag_req.address);
	assign lru_mru_way = pick_way;

	always_ff @(posedge clk)
	begin
		if (rst)
			resp_valid <= 1'b0;
		else if (!stall_pipeline)
			resp_valid <= tag_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			resp.req <= tag_req;
			resp.has_sm_data <= tag_has_sm_data;
			resp.hit <= tag_has_sm_data || cache_hit; // a fill counts as hit
			resp.way <= pick_way;
			resp.fill_line <= tag_sm_data;
		end
	end

endmodule

`default_nettype wire

// File: design/l2_tag_pipe.sv
// ##########################################################
// L2 tag pipeline top
// arbiter, tag and check stages around the pseudo-LRU
// ##########################################################

`default_nettype none
`timescale 1ns/1ps

module l2_tag_pipe
(
	input wire clk,
	input wire rst,
	input wire stall_pipeline,
	input wire core_valid,
	input wire l2_req_pkg::l2_req_t core_req,
	output logic core_accept,
	input wire sm_valid,
	input wire l2_req_pkg::l2_addr_t sm_addr,
	input wire l2_req_pkg::l2_way_t sm_fill_way,
	input wire l2_req_pkg::l2_line_t sm_data,
	output logic resp_valid,
	output l2_tag_pkg::l2_resp_t resp
);

	import l2_req_pkg::*;
	import l2_tag_pkg::*;

	logic init_busy;
	logic arb_valid;
	l2_req_t arb_req;
	logic arb_has_sm_data;
	l2_way_t arb_sm_fill_way;
	l2_line_t arb_sm_data;
	logic tag_valid;
	l2_req_t tag_req;
	logic tag_has_sm_data;
	l2_way_t tag_sm_fill_way;
	l2_line_t tag_sm_data;
	l2_lookup_t tag_lookup;
	l2_way_t tag_lru_way;
	l2_set_t lookup_set; // arb-stage set for the LRU read
	l2_way_t lookup_lru_way;
	logic lru_update;
	l2_set_t lru_set;
	l2_way_t lru_mru_way;

	l2_arb arb0
	(
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.core_valid(core_valid),
		.core_req(core_req),
		.core_accept(core_accept),
		.sm_valid(sm_valid),
		.sm_addr(sm_addr),
		.sm_fill_way(sm_fill_way),
		.sm_data(sm_data),
		.init_busy(init_busy),
		.arb_valid(arb_valid),
		.arb_req(arb_req),
		.arb_has_sm_data(arb_has_sm_data),
		.arb_sm_fill_way(arb_sm_fill_way),
		.arb_sm_data(arb_sm_data)
	);

	l2_cache_tag tag0
	(
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.arb_valid(arb_valid),
		.arb_req(arb_req),
		.arb_has_sm_data(arb_has_sm_data),
		.arb_sm_fill_way(arb_sm_fill_way),
		.arb_sm_data(arb_sm_data),
		.lru_way(lookup_lru_way),
		.lru_set(lookup_set),
		.init_busy(init_busy),
		.tag_valid(tag_valid),
		.tag_req(tag_req),
		.tag_has_sm_data(tag_has_sm_data),
		.tag_sm_fill_way(tag_sm_fill_way),
		.tag_sm_data(tag_sm_data),
		.tag_lookup(tag_lookup),
		.tag_lru_way(tag_lru_way)
	);

	l2_cache_lru lru0
	(
		.clk(clk),
		.rst(rst),
		.set_index(lookup_set),
		.lru_way(lookup_lru_way),
		.update(lru_update),
		.update_set(lru_set),
		.mru_way(lru_mru_way)
	);

	l2_tag_check check0
	(
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.tag_valid(tag_valid),
		.tag_req(tag_req),
		.tag_has_sm_data(tag_has_sm_data),
		.tag_sm_fill_way(tag_sm_fill_way),
		.tag_sm_data(tag_sm_data),
		.tag_lookup(tag_lookup),
		.tag_lru_way(tag_lru_way),
		.lru_update(lru_update),
		.lru_set(lru_set),
		.lru_mru_way(lru_mru_way),
		.resp_valid(resp_valid),
		.resp(resp)
	);

endmodule

`default_nettype wire

// File: bench/l2_tag_pipe_sva.sv
// ##########################################################
// L2 tag pipeline assertions
// stall hold, reset state and arbitration rules
// ##########################################################

`default_nettype none
`timescale 1ns/1ps

module l2_tag_pipe_sva
(
	input wire clk,
	input wire rst,
	input wire stall_pipeline,
	input wire core_accept,
	input wire sm_valid,
	input wire resp_valid,
	input wire l2_tag_pkg::l2_resp_t resp
);

	assert property (@(posedge clk) disable iff (rst)
		stall_pipeline |=> $stable(resp_valid))
		else $error("resp_valid changed while the pipe was stalled");

	// a held response keeps every field
	assert property (@(posedge clk) disable iff (rst)
		stall_pipeline && resp_valid |=> $stable(resp))
		else $error("resp changed while the pipe was stalled");

	assert property (@(posedge clk)
		$fell(rst) |-> !core_accept && !resp_valid)
		else $error("core_accept or resp_valid high right after reset");

	assert property (@(posedge clk) disable iff (rst)
		!(core_accept && sm_valid))
		else $error("core request accepted beside a restart");

endmodule

bind l2_tag_pipe l2_tag_pipe_sva sva0
(
	.clk(clk),
	.rst(rst),
	.stall_pipeline(stall_pipeline),
	.core_accept(core_accept),
	.sm_valid(sm_valid),
	.resp_valid(resp_valid),
	.resp(resp)
);

`default_nettype wire

// File: bench/l2_tag_pipe_tb.sv
// ##########################################################
// L2 tag pipeline testbench
// directed tests against a tag, valid and pseudo-LRU model
// ##########################################################

`default_nettype none
`timescale 1ns/1ps

`include "l2_params.svh"

module l2_tag_pipe_tb;

	import l2_req_pkg::*;
	import l2_tag_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int LATENCY = 2; // edges from accept to a visible response

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic stall_pipeline = 1'b0;
	logic core_valid = 1'b0;
	l2_req_t core_req = '0;
	logic core_accept;
	logic sm_valid = 1'b0;
	l2_addr_t sm_addr = '0;
	l2_way_t sm_fill_way = '0;
	l2_line_t sm_data = '0;
	logic resp_valid;
	l2_resp_t resp;

	int seed = 72917;
	int errors = 0;
	int checks = 0;
	int issued = 0;
	int seen = 0;
	bit random_stall = 1'b0;

	// reference state
	l2_tag_t ref_tag [`L2_NUM_WAYS][`L2_NUM_SETS];
	bit ref_valid [`L2_NUM_WAYS][`L2_NUM_SETS];
	bit [2:0] ref_lru [`L2_NUM_SETS];

	always #5 clk = ~clk;

	l2_tag_pipe dut0
	(
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.core_valid(core_valid),
		.core_req(core_req),
		.core_accept(core_accept),
		.sm_valid(sm_valid),
		.sm_addr(sm_addr),
		.sm_fill_way(sm_fill_way),
		.sm_data(sm_data),
		.resp_valid(resp_valid),
		.resp(resp)
	);

	// a response leaves on the next edge unless stalled
	always @(negedge clk)
	begin
		if (!rst && resp_valid && !stall_pipeline)
			seen++;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic abort_run(input string why);
		$display("Timeout at %0t: %s", $time, why);
		$display("responses checked %0d, errors %0d", checks, errors + 1);
		$display("Simulation FAILED");
		$finish;
	endtask

	function automatic l2_way_t lru_victim(input l2_set_t s);
		if (ref_lru[s][0])
			return l2_way_t'(2 + ref_lru[s][2]);
		return l2_way_t'(ref_lru[s][1]);
	endfunction

	// point every tree bit on the path away from the used way
	function automatic void touch_lru(input l2_set_t s, input l2_way_t w);
		ref_lru[s][0] = (w < 2);
		if (w < 2)
			ref_lru[s][1] = (w == 0);
		else
			ref_lru[s][2] = (w == 2);
	endfunction

	function automatic void record_fill(input l2_addr_t a, input l2_way_t w);
		l2_set_t s;
		s = a[`L2_SET_INDEX_WIDTH-1:0];
		ref_tag[w][s] = a[`L2_ADDR_WIDTH-1:`L2_SET_INDEX_WIDTH];
		ref_valid[w][s] = 1'b1;
		touch_lru(s, w);
	endfunction

	function automatic void predict_lookup(input l2_addr_t a, output bit hit, output l2_way_t way);
		l2_set_t s;
		l2_tag_t t;
		bit free;
		s = a[`L2_SET_INDEX_WIDTH-1:0];
		t = a[`L2_ADDR_WIDTH-1:`L2_SET_INDEX_WIDTH];
		hit = 1'b0;
		free = 1'b0;
		way = '0;
		for (int w = 0; w < `L2_NUM_WAYS; w++)
		begin
			if (!hit && ref_valid[w][s] && ref_tag[w][s] == t)
			begin
				hit = 1'b1;
				way = l2_way_t'(w);
			end
		end
		for (int w = 0; w < `L2_NUM_WAYS; w++)
		begin
			if (!hit && !free && !ref_valid[w][s])
			begin
				free = 1'b1; // lowest invalid way
				way = l2_way_t'(w);
			end
		end
		if (!hit && !free)
			way = lru_victim(s);
		touch_lru(s, way);
	endfunction

	function automatic l2_line_t fresh_line();
		l2_line_t v;
		for (int i = 0; i < `L2_LINE_WIDTH / 32; i++)
			v[i*32 +: 32] = $random(seed);
		return v;
	endfunction

	function automatic l2_req_t core_request(input l2_addr_t a);
		l2_req_t r;
		r.unit = l2_unit_t'($random(seed));
		r.strand = l2_strand_t'($random(seed));
		r.op = l2_op_t'($random(seed));
		r.address = a;
		r.data = fresh_line();
		r.mask = {$random(seed), $random(seed)};
		return r;
	endfunction

	// first core request waits out reset and the tag clear
	task automatic reset_dut();
		l2_req_t r;
		int n;
		for (int s = 0; s < `L2_NUM_SETS; s++)
		begin
			ref_lru[s] = '0;
			for (int w = 0; w < `L2_NUM_WAYS; w++)
				ref_valid[w][s] = 1'b0;
		end
		r = core_request(l2_addr_t'($random(seed)));
		rst <= 1'b1;
		core_valid <= 1'b1;
		core_req <= r;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!core_accept) // tag clear sweep
		begin
			n++;
			if (n > WAIT_LIMIT)
				abort_run("core request after reset was never accepted");
			@(negedge clk);
		end
		if (n != `L2_NUM_SETS)
			report_error($sformatf("first accept after %0d cycles, expected %0d",
				n, `L2_NUM_SETS));
		finish_core(r);
	endtask

	task automatic wait_accept();
		int n;
		n = 0;
		@(negedge clk);
		while (!core_accept)
		begin
			n++;
			if (n > WAIT_LIMIT)
				abort_run("core request was never accepted");
			@(negedge clk);
		end
	endtask

	// request is sampled on the edge after the accept was seen
	task automatic finish_core(input l2_req_t r);
		l2_resp_t got;
		bit hit;
		l2_way_t way;
		int cycles;
		int stalled;
		@(posedge clk);
		core_valid <= 1'b0;
		issued++;
		wait_resp(got, cycles, stalled);
		predict_lookup(r.address, hit, way);
		check_resp(got, r, 1'b0, hit, way, '0, cycles, LATENCY + stalled);
	endtask

	task automatic restart_fill(input l2_addr_t a, input l2_way_t w, input l2_line_t d);
		@(posedge clk);
		sm_valid <= 1'b1;
		sm_addr <= a;
		sm_fill_way <= w;
		sm_data <= d;
		@(posedge clk); // taken here since stall is low
		sm_valid <= 1'b0;
		issued++;
	endtask

	// called on the accept edge to count edges and stalled edges
	task automatic wait_resp(output l2_resp_t got, output int cycles, output int stalled);
		cycles = 0;
		stalled = 0;
		forever
		begin
			if (random_stall)
				stall_pipeline <= ($random(seed) & 3) == 0;
			@(negedge clk);
			if (resp_valid)
				break;
			if (stall_pipeline)
				stalled++;
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("no response from the pipeline");
			@(posedge clk);
		end
		got = resp;
		@(posedge clk);
		stall_pipeline <= 1'b0;
	endtask

	task automatic check_resp(input l2_resp_t got, input l2_req_t r, input bit sm,
		input bit hit, input l2_way_t way, input l2_line_t line, input int cycles,
		input int exp_cycles);
		checks++;
		if (!sm && got.req !== r)
			report_error("core request fields changed on the way through");
		if (got.req.address !== r.address)
			report_error($sformatf("address %h, expected %h", got.req.address, r.address));
		if (got.has_sm_data !== sm)
			report_error($sformatf("has_sm_data %0b, expected %0b", got.has_sm_data, sm));
		if (got.hit !== hit)
			report_error($sformatf("hit %0b, expected %0b", got.hit, hit));
		if (got.way !== way)
			report_error($sformatf("way %0d, expected %0d", got.way, way));
		if (sm && got.fill_line !== line)
			report_error("fill line differs from the restart data");
		if (cycles != exp_cycles)
			report_error($sformatf("latency %0d, expected %0d", cycles, exp_cycles));
	endtask

	task automatic core_roundtrip(input l2_addr_t a);
		l2_req_t r;
		r = core_request(a);
		@(posedge clk);
		core_valid <= 1'b1;
		core_req <= r;
		wait_accept();
		finish_core(r);
	endtask

	task automatic fill_roundtrip(input l2_addr_t a, input l2_way_t w);
		l2_line_t d;
		l2_req_t r;
		l2_resp_t got;
		int cycles;
		int stalled;
		d = fresh_line();
		r = '0;
		r.address = a;
		restart_fill(a, w, d);
		record_fill(a, w);
		wait_resp(got, cycles, stalled);
		check_resp(got, r, 1'b1, 1'b1, w, d, cycles, LATENCY + stalled);
	endtask

	task automatic cold_miss();
		repeat (4) core_roundtrip(l2_addr_t'($random(seed))); // all invalid, way 0
	endtask

	task automatic fill_then_hit();
		l2_addr_t a;
		repeat (4)
		begin
			a = l2_addr_t'($random(seed));
			fill_roundtrip(a, l2_way_t'($random(seed)));
			core_roundtrip(a);
		end
	endtask

	task automatic victim_choice();
		l2_tag_t base;
		l2_set_t s;
		base = l2_tag_t'($random(seed));
		s = 6'h2a;
		for (int k = 0; k < `L2_NUM_WAYS; k++)
			fill_roundtrip({l2_tag_t'(base + k), s}, l2_way_t'(k));
		core_roundtrip({l2_tag_t'(base + 4), s}); // miss picks the LRU way
		core_roundtrip({l2_tag_t'(base + 1), s});
		core_roundtrip({l2_tag_t'(base + 4), s});
		core_roundtrip({l2_tag_t'(base + 3), s});
		core_roundtrip({l2_tag_t'(base + 0), s});
		core_roundtrip({l2_tag_t'(base + 4), s});
	endtask

	task automatic core_vs_restart();
		l2_req_t r;
		l2_line_t d;
		l2_way_t w;
		l2_resp_t got;
		bit hit;
		l2_way_t way;
		int cycles;
		int stalled;
		r = core_request(l2_addr_t'($random(seed)));
		d = fresh_line();
		w = l2_way_t'($random(seed));
		@(posedge clk);
		core_valid <= 1'b1;
		core_req <= r;
		sm_valid <= 1'b1;
		sm_addr <= r.address;
		sm_fill_way <= w;
		sm_data <= d;
		@(negedge clk);
		if (core_accept)
			report_error("core request accepted beside a restart");
		@(posedge clk);
		sm_valid <= 1'b0;
		wait_accept();
		@(posedge clk);
		core_valid <= 1'b0;
		issued += 2;
		record_fill(r.address, w);
		wait_resp(got, cycles, stalled); // restart went in one edge earlier
		check_resp(got, r, 1'b1, 1'b1, w, d, cycles, LATENCY - 1);
		predict_lookup(r.address, hit, way);
		wait_resp(got, cycles, stalled);
		check_resp(got, r, 1'b0, hit, way, d, cycles, 0);
	endtask

	task automatic stall_delays();
		l2_addr_t a;
		random_stall = 1'b1;
		repeat (10)
		begin
			a = l2_addr_t'($random(seed));
			if ($random(seed) & 1)
				fill_roundtrip(a, l2_way_t'($random(seed)));
			else
				core_roundtrip(a);
		end
		random_stall = 1'b0;
	endtask

	task automatic set_independence();
		l2_tag_t t;
		t = l2_tag_t'($random(seed));
		fill_roundtrip({t, 6'h05}, 2'd2);
		core_roundtrip({t, 6'h06}); // same tag, other set
		core_roundtrip({t, 6'h05});
	endtask

	initial
	begin
		reset_dut();
		cold_miss();
		fill_then_hit();
		victim_choice();
		core_vs_restart();
		stall_delays();
		set_independence();
		repeat (4) @(posedge clk);
		if (seen != issued)
			report_error($sformatf("%0d responses for %0d requests", seen, issued));
		$display("responses checked %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/l2_req_pkg.sv
design/l2_tag_pkg.sv
design/l2_arb.sv
design/l2_cache_tag.sv
design/l2_cache_lru.sv
design/l2_tag_check.sv
design/l2_tag_pipe.sv
bench/l2_tag_pipe_sva.sv
bench/l2_tag_pipe_tb.sv

// File: Bender.yml
package:
  name: l2_tag_pipe

sources:
  - include_dirs:
      - design
    files:
      - design/l2_req_pkg.sv
      - design/l2_tag_pkg.sv
      - design/l2_arb.sv
      - design/l2_cache_tag.sv
      - design/l2_cache_lru.sv
      - design/l2_tag_check.sv
      - design/l2_tag_pipe.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/l2_tag_pipe_sva.sv
      - bench/l2_tag_pipe_tb.sv
